// File: hdl/core_pkg.sv
`default_nettype none

package core_pkg;

  // ****************************************
  // widths
  // ****************************************

  localparam int XLEN      = 32;
  localparam int NREG      = 32;
  localparam int REG_AW    = 5;
  localparam int IMM_W     = 16;

  // the multiplier retires two multiplier bits per step
  localparam int MUL_STEPS = 16;
  localparam int MUL_CW    = $clog2(MUL_STEPS);

  // ****************************************
  // opcodes
  // ****************************************

  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_OR  = 4'd3,
    OP_XOR = 4'd4,
    OP_SLL = 4'd5,
    OP_LI  = 4'd6,
    OP_MUL = 4'd7
  } op_e;

  // ****************************************
  // payloads
  // ****************************************

  // one instruction as it arrives at the cluster
  typedef struct packed {
    op_e               op;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [IMM_W-1:0]  imm;
  } instr_t;

  // operand b carries the zero-extended immediate for OP_LI
  typedef struct packed {
    op_e               op;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
  } exec_req_t;

  // a unit result, and also the commit on the writeback bus
  typedef struct packed {
    logic              valid;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   data;
  } result_t;

endpackage

`default_nettype wire

// File: hdl/reg_scoreboard.sv
`timescale 1ns/1ns
`default_nettype none

module reg_scoreboard
  import core_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  logic [REG_AW-1:0] rs1_i,
  input  logic [REG_AW-1:0] rs2_i,
  input  logic [REG_AW-1:0] rd_i,
  input  logic              use_rs1_i,
  input  logic              use_rs2_i,
  input  logic              issue_i,
  input  result_t           commit_i,
  output logic [XLEN-1:0]   rdata1_o,
  output logic [XLEN-1:0]   rdata2_o,
  output logic              hazard_o
);

  logic [XLEN-1:0] regs [NREG];
  logic [NREG-1:0] busy_q;
  logic [NREG-1:0] busy_d;
  logic            commit_wr;
  logic            bypass1;
  logic            bypass2;
  logic            raw1;
  logic            raw2;
  logic            waw;

  // register 0 is never written and never marked busy
  assign commit_wr = commit_i.valid && (commit_i.rd != '0);

  // ****************************************
  // register array
  // ****************************************

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (commit_wr) begin
      regs[commit_i.rd] <= commit_i.data;
    end
  end

  // ****************************************
  // busy bits
  // ****************************************

  // the issue set is applied after the commit clear so a set wins
  always_comb begin
    busy_d = busy_q;
    if (commit_wr) begin
      busy_d[commit_i.rd] = 1'b0;
    end
    if (issue_i && (rd_i != '0)) begin
      busy_d[rd_i] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_d;
    end
  end

  // ****************************************
  // reads, bypass and hazards
  // ****************************************

  assign bypass1 = commit_wr && (commit_i.rd == rs1_i);
  assign bypass2 = commit_wr && (commit_i.rd == rs2_i);

  assign rdata1_o = bypass1 ? commit_i.data : regs[rs1_i];
  assign rdata2_o = bypass2 ? commit_i.data : regs[rs2_i];

  // a source being committed this cycle is already good through the bypass
  assign raw1 = use_rs1_i && busy_q[rs1_i] && !bypass1;
  assign raw2 = use_rs2_i && busy_q[rs2_i] && !bypass2;

  // only one write per destination may be in flight
  assign waw = busy_q[rd_i];

  assign hazard_o = raw1 || raw2 || waw;

endmodule

`default_nettype wire

// File: hdl/issue_stage.sv
`timescale 1ns/1ns
`default_nettype none

module issue_stage
  import core_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  instr_t            instr_i,
  input  logic              instr_valid_i,
  output logic              instr_ready_o,
  output logic [REG_AW-1:0] rs1_o,
  output logic [REG_AW-1:0] rs2_o,
  output logic [REG_AW-1:0] rd_o,
  output logic              use_rs1_o,
  output logic              use_rs2_o,
  input  logic [XLEN-1:0]   rdata1_i,
  input  logic [XLEN-1:0]   rdata2_i,
  input  logic              hazard_i,
  output logic              issue_o,
  output exec_req_t         alu_req_o,
  output exec_req_t         mul_req_o,
  output logic              alu_valid_o,
  output logic              mul_valid_o,
  input  logic              alu_ready_i,
  input  logic              mul_ready_i
);

  logic      run_q;
  logic      is_mul;
  logic      free;
  exec_req_t req;

  // ready stays low until the first edge that sees reset released
  always_ff @(posedge clock) begin
    if (reset) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  // ****************************************
  // decode
  // ****************************************

  assign is_mul    = (instr_i.op == OP_MUL);
  assign use_rs1_o = (instr_i.op != OP_LI);

  always_comb begin
    case (instr_i.op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_MUL: use_rs2_o = 1'b1;
      default: use_rs2_o = 1'b0;
    endcase
  end

  assign rs1_o = instr_i.rs1;
  assign rs2_o = instr_i.rs2;
  assign rd_o  = instr_i.rd;

  // ****************************************
  // dispatch
  // ****************************************

  always_comb begin
    req.op = instr_i.op;
    req.rd = instr_i.rd;
    req.a  = rdata1_i;
    if (instr_i.op == OP_LI) begin
      req.b = {{(XLEN-IMM_W){1'b0}}, instr_i.imm};
    end else begin
      req.b = rdata2_i;
    end
  end

  assign alu_req_o = req;
  assign mul_req_o = req;

  assign free          = run_q && !hazard_i;
  assign instr_ready_o = free && (is_mul ? mul_ready_i : alu_ready_i);
  assign alu_valid_o   = instr_valid_i && free && !is_mul;
  assign mul_valid_o   = instr_valid_i && free && is_mul;
  assign issue_o       = instr_valid_i && instr_ready_o;

endmodule

`default_nettype wire

// File: hdl/alu_unit.sv
`timescale 1ns/1ns
`default_nettype none

module alu_unit
  import core_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  exec_req_t req_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  output result_t   result_o,
  input  logic      grant_i
);

  logic [XLEN-1:0] alu_out;
  logic            accept;
  result_t         res_q;

  always_comb begin
    case (req_i.op)
      OP_ADD:  alu_out = req_i.a + req_i.b;
      OP_SUB:  alu_out = req_i.a - req_i.b;
      OP_AND:  alu_out = req_i.a & req_i.b;
      OP_OR:   alu_out = req_i.a | req_i.b;
      OP_XOR:  alu_out = req_i.a ^ req_i.b;
      OP_SLL:  alu_out = req_i.a << req_i.b[4:0];
      OP_LI:   alu_out = req_i.b;
      default: alu_out = '0;
    endcase
  end

  // a new op can replace a result in the cycle it is granted
  assign req_ready_o = !res_q.valid || grant_i;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      res_q.valid <= 1'b0;
    end else if (accept) begin
      res_q.valid <= 1'b1;
      res_q.rd    <= req_i.rd;
      res_q.data  <= alu_out;
    end else if (grant_i) begin
      res_q.valid <= 1'b0;
    end
  end

  assign result_o = res_q;

endmodule

`default_nettype wire

// File: hdl/mul_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mul_unit
  import core_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  exec_req_t req_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  output result_t   result_o,
  input  logic      grant_i
);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } mul_state_e;

  mul_state_e        state_q;
  logic [MUL_CW-1:0] step_q;
  logic [XLEN-1:0]   mcand_q;
  logic [XLEN-1:0]   mplier_q;
  logic [XLEN-1:0]   acc_q;
  logic [REG_AW-1:0] rd_q;
  logic [XLEN-1:0]   part0;
  logic [XLEN-1:0]   part1;
  logic              accept;

  assign req_ready_o = (state_q == IDLE);
  assign accept      = req_valid_i && req_ready_o;

  // ****************************************
  // control
  // ****************************************

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= RUN;
            step_q  <= '0;
          end
        end
        RUN: begin
          step_q <= step_q + 1'b1;
          if (step_q == MUL_CW'(MUL_STEPS - 1)) begin
            state_q <= DONE;
          end
        end
        DONE: begin
          if (grant_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // ****************************************
  // shift-add datapath
  // ****************************************

  // only the low word is kept, so the multiplicand never needs to grow
  assign part0 = mplier_q[0] ? mcand_q : '0;
  assign part1 = mplier_q[1] ? {mcand_q[XLEN-2:0], 1'b0} : '0;

  always_ff @(posedge clock) begin
    if (accept) begin
      mcand_q  <= req_i.a;
      mplier_q <= req_i.b;
      acc_q    <= '0;
      rd_q     <= req_i.rd;
    end else if (state_q == RUN) begin
      acc_q    <= acc_q + part0 + part1;
      mcand_q  <= {mcand_q[XLEN-3:0], 2'b00};
      mplier_q <= mplier_q >> 2;
    end
  end

  assign result_o = '{valid: (state_q == DONE), rd: rd_q, data: acc_q};

endmodule

`default_nettype wire

// File: hdl/writeback_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_arbiter
  import core_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  result_t alu_res_i,
  input  result_t mul_res_i,
  output logic    alu_grant_o,
  output logic    mul_grant_o,
  output result_t commit_o
);

  // when set the multiplier wins a tie
  logic    prio_q;
  result_t commit_q;

  assign alu_grant_o = alu_res_i.valid && (!mul_res_i.valid || !prio_q);
  assign mul_grant_o = mul_res_i.valid && (!alu_res_i.valid || prio_q);

  // ****************************************
  // registered commit
  // ****************************************

  always_ff @(posedge clock) begin
    if (reset) begin
      prio_q         <= 1'b0;
      commit_q.valid <= 1'b0;
    end else begin
      commit_q.valid <= alu_grant_o || mul_grant_o;
      if (alu_grant_o) begin
        commit_q.rd   <= alu_res_i.rd;
        commit_q.data <= alu_res_i.data;
        prio_q        <= 1'b1;
      end else if (mul_grant_o) begin
        commit_q.rd   <= mul_res_i.rd;
        commit_q.data <= mul_res_i.data;
        prio_q        <= 1'b0;
      end
    end
  end

  assign commit_o = commit_q;

endmodule

`default_nettype wire

// File: hdl/exec_cluster_top.sv
`timescale 1ns/1ns
`default_nettype none

module exec_cluster_top
  import core_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  instr_t  instr_i,
  input  logic    instr_valid_i,
  output logic    instr_ready_o,
  output result_t commit_o
);

  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [REG_AW-1:0] rd;
  logic              use_rs1;
  logic              use_rs2;
  logic [XLEN-1:0]   rdata1;
  logic [XLEN-1:0]   rdata2;
  logic              hazard;
  logic              issue;
  exec_req_t         alu_req;
  exec_req_t         mul_req;
  logic              alu_valid;
  logic              mul_valid;
  logic              alu_ready;
  logic              mul_ready;
  result_t           alu_res;
  result_t           mul_res;
  logic              alu_grant;
  logic              mul_grant;

  issue_stage issue_stage_inst (
    .clock, .reset, .instr_i, .instr_valid_i, .instr_ready_o,
    .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .use_rs1_o(use_rs1), .use_rs2_o(use_rs2),
    .rdata1_i(rdata1), .rdata2_i(rdata2), .hazard_i(hazard), .issue_o(issue),
    .alu_req_o(alu_req), .mul_req_o(mul_req), .alu_valid_o(alu_valid),
    .mul_valid_o(mul_valid), .alu_ready_i(alu_ready), .mul_ready_i(mul_ready)
  );

  reg_scoreboard reg_scoreboard_inst (
    .clock, .reset, .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd),
    .use_rs1_i(use_rs1), .use_rs2_i(use_rs2), .issue_i(issue), .commit_i(commit_o),
    .rdata1_o(rdata1), .rdata2_o(rdata2), .hazard_o(hazard)
  );

  alu_unit alu_unit_inst (
    .clock, .reset, .req_i(alu_req), .req_valid_i(alu_valid), .req_ready_o(alu_ready),
    .result_o(alu_res), .grant_i(alu_grant)
  );

  mul_unit mul_unit_inst (
    .clock, .reset, .req_i(mul_req), .req_valid_i(mul_valid), .req_ready_o(mul_ready),
    .result_o(mul_res), .grant_i(mul_grant)
  );

  writeback_arbiter writeback_arbiter_inst (
    .clock, .reset, .alu_res_i(alu_res), .mul_res_i(mul_res),
    .alu_grant_o(alu_grant), .mul_grant_o(mul_grant), .commit_o
  );

endmodule

`default_nettype wire

// File: sim/exec_cluster_chk.sv
`timescale 1ns/1ns
`default_nettype none

module exec_cluster_chk
  import core_pkg::*;
(
  input logic              clock,
  input logic              reset,
  input logic              issue_i,
  input logic [REG_AW-1:0] rs1_i,
  input logic [REG_AW-1:0] rs2_i,
  input logic [REG_AW-1:0] rd_i,
  input logic              use_rs1_i,
  input logic              use_rs2_i,
  input result_t           commit_i,
  input logic [NREG-1:0]   busy_i
);

  // ****************************************
  // scoreboard rules
  // ****************************************

  // a commit always finds its destination marked busy
  assert property (@(posedge clock) disable iff (reset)
    (commit_i.valid && commit_i.rd != '0) |-> busy_i[commit_i.rd])
    else $error("commit to a register that is not busy");

  // an issued source is either idle or being committed now, and its destination is idle
  assert property (@(posedge clock) disable iff (reset)
    issue_i |-> !busy_i[rd_i]
      && (!use_rs1_i || !busy_i[rs1_i] || (commit_i.valid && commit_i.rd == rs1_i))
      && (!use_rs2_i || !busy_i[rs2_i] || (commit_i.valid && commit_i.rd == rs2_i)))
    else $error("instruction issued while a hazard is present");

  assert property (@(posedge clock)
    reset |=> (busy_i == '0))
    else $error("busy bits not clear after reset");

endmodule

bind reg_scoreboard exec_cluster_chk exec_cluster_chk_inst (
  .clock     (clock),
  .reset     (reset),
  .issue_i   (issue_i),
  .rs1_i     (rs1_i),
  .rs2_i     (rs2_i),
  .rd_i      (rd_i),
  .use_rs1_i (use_rs1_i),
  .use_rs2_i (use_rs2_i),
  .commit_i  (commit_i),
  .busy_i    (busy_q)
);

`default_nettype wire

// File: sim/exec_cluster_tb.sv
`timescale 1ns/1ns
`default_nettype none

module exec_cluster_tb
  import core_pkg::*;
;

  localparam int          CLK_PERIOD     = 40;
  localparam int          RESET_CYCLES   = 16;
  localparam int          NUM_INSTR      = 400;
  localparam int          REG_POOL       = 6;
  localparam int          TIMEOUT_CYCLES = NUM_INSTR * (MUL_STEPS + 4) * 2;
  localparam logic [31:0] SEED           = 32'he712_5d93;

  logic    clock;
  logic    reset;
  instr_t  instr;
  logic    instr_valid;
  logic    instr_ready;
  result_t commit;

  // architectural state in program order, plus one expected slot per register
  logic [XLEN-1:0] model_regs [NREG];
  logic [XLEN-1:0] slot_data [NREG];
  logic            slot_full [NREG];
  // writes to r0 may overlap, so they are matched by value
  logic [XLEN-1:0] zero_q [$];
  int              pending = 0;
  int              accepted = 0;
  int              cycle_count = 0;

  exec_cluster_top exec_cluster_top_inst (
    .clock         (clock),
    .reset         (reset),
    .instr_i       (instr),
    .instr_valid_i (instr_valid),
    .instr_ready_o (instr_ready),
    .commit_o      (commit)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "stopping at first error");
  endtask

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  // ****************************************
  // reference model
  // ****************************************

  function automatic logic [XLEN-1:0] expected_result(op_e op, logic [XLEN-1:0] a,
                                                       logic [XLEN-1:0] b, logic [15:0] imm);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[4:0];
      OP_LI:   return {16'h0000, imm};
      default: return a * b;
    endcase
  endfunction

  // register fields come from a small pool so that dependences are frequent
  function automatic instr_t random_instr();
    instr_t      ins;
    int unsigned pick;
    pick = $urandom % 20;
    if (pick < 4) begin
      ins.op = OP_MUL;
    end else if (pick < 8) begin
      ins.op = OP_LI;
    end else begin
      ins.op = op_e'(4'((pick - 8) % 6));
    end
    ins.rd  = REG_AW'($urandom % REG_POOL);
    ins.rs1 = REG_AW'($urandom % REG_POOL);
    ins.rs2 = REG_AW'($urandom % REG_POOL);
    ins.imm = 16'($urandom);
    return ins;
  endfunction

  task automatic record_issue(instr_t ins);
    logic [XLEN-1:0] value;
    value = expected_result(ins.op, model_regs[ins.rs1], model_regs[ins.rs2], ins.imm);
    if (ins.rd == '0) begin
      zero_q.push_back(value);
    end else begin
      assert (!slot_full[ins.rd]) else begin
        $display("second write to r%0d accepted while one is in flight", ins.rd);
        abort_run();
      end
      slot_full[ins.rd]  = 1'b1;
      slot_data[ins.rd]  = value;
      model_regs[ins.rd] = value;
    end
    pending++;
    accepted++;
  endtask

  task automatic check_commit();
    result_t c;
    int      idx;
    logic    found;
    c     = commit;
    idx   = 0;
    found = 1'b0;
    if (accepted == 0) begin
      assert (!c.valid) else begin
        $display("commit seen before any instruction was accepted");
        abort_run();
      end
    end
    if (c.valid) begin
      if (c.rd == '0) begin
        for (int i = 0; i < zero_q.size(); i++) begin
          if (!found && zero_q[i] == c.data) begin
            idx   = i;
            found = 1'b1;
          end
        end
        assert (found) else begin
          $display("Fail %0t: r0 committed %h, which no write to r0 expects", $time, c.data);
          abort_run();
        end
        zero_q.delete(idx);
      end else begin
        assert (slot_full[c.rd]) else begin
          $display("commit to r%0d with no instruction in flight", c.rd);
          abort_run();
        end
        assert (c.data == slot_data[c.rd]) else begin
          $display("Fail %0t: r%0d committed %h, expected %h", $time, c.rd, c.data,
                   slot_data[c.rd]);
          abort_run();
        end
        slot_full[c.rd] = 1'b0;
      end
      pending--;
    end
  endtask

  // ****************************************
  // stimulus
  // ****************************************

  initial begin
    int   sent;
    logic holding;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    sent        = 0;
    holding     = 1'b0;
    void'($urandom(SEED));
    for (int i = 0; i < NREG; i++) begin
      model_regs[i] = '0;
      slot_data[i]  = '0;
      slot_full[i]  = 1'b0;
    end

    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    assert (instr_ready) else begin
      $display("instr_ready_o is low in the first cycle after reset");
      abort_run();
    end

    while (sent < NUM_INSTR) begin
      @(negedge clock);
      check_commit();
      if (!holding) begin
        if ($urandom % 8 == 0) begin
          instr_valid = 1'b0;
        end else begin
          instr       = random_instr();
          instr_valid = 1'b1;
          holding     = 1'b1;
        end
      end
      // ready is settled here and holds until the next rising edge
      #(CLK_PERIOD / 4);
      if (instr_valid && instr_ready) begin
        record_issue(instr);
        sent++;
        holding = 1'b0;
      end
    end
    @(negedge clock);
    check_commit();
    instr_valid = 1'b0;

    while (pending > 0) begin
      @(negedge clock);
      check_commit();
    end
    // nothing more may commit once every slot is empty
    repeat (MUL_STEPS + 4) begin
      @(negedge clock);
      check_commit();
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
hdl/core_pkg.sv
hdl/reg_scoreboard.sv
hdl/issue_stage.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/writeback_arbiter.sv
hdl/exec_cluster_top.sv
sim/exec_cluster_chk.sv
sim/exec_cluster_tb.sv
